/* src/fm_stereo_pkg.sv */
package fm_stereo_pkg;

    localparam int DATA_SIZE = 32;
    localparam int QUANT_BITS = 10;
    localparam int NUM_TAPS = 32;
    localparam int AUDIO_DECIMATION = 8;

    typedef logic signed [DATA_SIZE-1:0] sample_t;
    typedef logic signed [2*DATA_SIZE-1:0] product_t;
    typedef logic [2:0] phase_t;

    // Unity gain in Q10
    localparam sample_t GAIN_Q = sample_t'(1 << QUANT_BITS);

    // Index 0 multiplies the newest sample
    typedef sample_t [0:NUM_TAPS-1] coeff_table_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    typedef enum logic [2:0] {
        IDLE,
        FRONT,
        SQUARE,
        HP,
        MIX,
        LMR,
        FORM,
        WRITE
    } seq_state_t;

    localparam coeff_table_t BP_PILOT_COEFFS = '{
           14,    31,    52,    72,    78,    54,    -8,  -104,
         -211,  -294,  -317,  -258,  -118,    74,   271,   417,
          417,   271,    74,  -118,  -258,  -317,  -294,  -211,
         -104,    -8,    54,    78,    72,    52,    31,    14
    };

    localparam coeff_table_t BP_LMR_COEFFS = '{
            0,     0,    -4,    -7,    -2,     8,    12,     2,
            3,    30,    48,    -4,  -116,  -168,   -61,   138,
          138,   -61,  -168,  -116,    -4,    48,    30,     3,
            2,    12,     8,    -2,    -7,    -4,     0,     0
    };

    localparam coeff_table_t HP_COEFFS = '{
           -1,     0,     0,     2,     4,     8,    11,    12,
            8,    -1,   -18,   -41,   -69,   -97,  -121,  -138,
         -138,  -121,   -97,   -69,   -41,   -18,    -1,     8,
           12,    11,     8,     4,     2,     0,     0,    -1
    };

    localparam coeff_table_t AUDIO_LPR_COEFFS = '{
           -3,    -6,   -12,   -19,   -27,   -33,   -30,   -13,
           21,    78,   155,   249,   349,   446,   526,   579,
          579,   526,   446,   349,   249,   155,    78,    21,
          -13,   -30,   -33,   -27,   -19,   -12,    -6,    -3
    };

    localparam coeff_table_t AUDIO_LMR_COEFFS = '{
           -3,    -6,   -12,   -19,   -27,   -33,   -30,   -13,
           21,    78,   155,   249,   349,   446,   526,   579,
          579,   526,   446,   349,   249,   155,    78,    21,
          -13,   -30,   -33,   -27,   -19,   -12,    -6,    -3
    };

    // Drop the Q10 fraction of a full-width product
    function automatic sample_t dequantize(input product_t prod);
        return sample_t'(prod >>> QUANT_BITS);
    endfunction

endpackage

/* src/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                   clock,
    input  logic                   i_rst_n,
    input  logic                   i_wr_en,
    input  fm_stereo_pkg::sample_t i_data,
    output logic                   o_full,
    input  logic                   i_rd_en,
    output fm_stereo_pkg::sample_t o_data,
    output logic                   o_empty
);

    import fm_stereo_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sample_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head word falls through
    assign o_data = mem[rd_ptr];
    assign o_empty = (count == '0);
    assign o_full = (count == CNT_W'(DEPTH));

    always_ff @(posedge clock) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_wr_en, i_rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (!i_rst_n)
        i_wr_en |-> !o_full) else $error("write while full");
    a_no_underflow: assert property (@(posedge clock) disable iff (!i_rst_n)
        i_rd_en |-> !o_empty) else $error("read while empty");

endmodule

/* src/fir_mac.sv */
`timescale 1ns/1ps

module fir_mac #(
    parameter fm_stereo_pkg::coeff_table_t COEFFS = '0
) (
    input  logic                   clock,
    input  logic                   i_rst_n,
    input  logic                   i_shift,
    input  fm_stereo_pkg::sample_t i_sample,
    input  logic                   i_start,
    output logic                   o_done,
    output fm_stereo_pkg::sample_t o_result
);

    import fm_stereo_pkg::*;

    localparam int IDX_W = $clog2(NUM_TAPS);

    sample_t taps [NUM_TAPS];
    logic [IDX_W-1:0] idx;
    logic busy;
    logic last_tap;
    sample_t acc;
    sample_t coeff;
    product_t prod;
    sample_t term;

    // One multiplier walks the taps
    assign coeff = COEFFS[idx];
    assign prod = taps[idx] * coeff;
    assign term = dequantize(prod);
    assign last_tap = busy && (idx == IDX_W'(NUM_TAPS - 1));

    // Newest sample enters at tap 0
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                taps[k] <= '0;
            end
        end else if (i_shift) begin
            taps[0] <= i_sample;
            for (int k = 1; k < NUM_TAPS; k++) begin
                taps[k] <= taps[k-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            busy <= 1'b0;
            idx <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= last_tap;
            if (i_start) begin
                busy <= 1'b1;
                idx <= '0;
            end else if (busy) begin
                idx <= idx + 1'b1;
                if (last_tap) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (i_start) begin
            acc <= '0;
        end else if (busy) begin
            acc <= acc + term;
        end
    end

    // Result holds until the next pass completes
    always_ff @(posedge clock) begin
        if (last_tap) begin
            o_result <= acc + term;
        end
    end

    a_start_idle: assert property (@(posedge clock) disable iff (!i_rst_n)
        i_start |-> !busy) else $error("filter started while busy");

endmodule

/* src/pilot_mixer.sv */
`timescale 1ns/1ps

module pilot_mixer (
    input  logic                   clock,
    input  logic                   i_rst_n,
    input  logic                   i_square,
    input  fm_stereo_pkg::sample_t i_pilot,
    output fm_stereo_pkg::sample_t o_carrier_sq,
    input  logic                   i_mix,
    input  fm_stereo_pkg::sample_t i_carrier,
    input  fm_stereo_pkg::sample_t i_lmr_band,
    output fm_stereo_pkg::sample_t o_mixed
);

    import fm_stereo_pkg::*;

    product_t pilot_sq;
    product_t mix_prod;

    // Squaring the 19 kHz pilot gives the 38 kHz carrier
    assign pilot_sq = i_pilot * i_pilot;
    // Shift the L-R band down to baseband
    assign mix_prod = i_carrier * i_lmr_band;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            o_carrier_sq <= '0;
            o_mixed <= '0;
        end else begin
            if (i_square) begin
                o_carrier_sq <= dequantize(pilot_sq);
            end
            if (i_mix) begin
                o_mixed <= dequantize(mix_prod);
            end
        end
    end

endmodule

/* src/stereo_matrix.sv */
`timescale 1ns/1ps

module stereo_matrix (
    input  logic                          clock,
    input  logic                          i_rst_n,
    input  logic                          i_form,
    input  fm_stereo_pkg::sample_t        i_lpr,
    input  fm_stereo_pkg::sample_t        i_lmr,
    output fm_stereo_pkg::stereo_sample_t o_pair
);

    import fm_stereo_pkg::*;

    sample_t sum;
    sample_t diff;
    product_t left_prod;
    product_t right_prod;

    // Sum and difference wrap at DATA_SIZE
    assign sum = i_lpr + i_lmr;
    assign diff = i_lpr - i_lmr;
    assign left_prod = sum * GAIN_Q;
    assign right_prod = diff * GAIN_Q;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            o_pair <= '0;
        end else if (i_form) begin
            o_pair.left <= dequantize(left_prod);
            o_pair.right <= dequantize(right_prod);
        end
    end

endmodule

/* src/demod_sequencer.sv */
`timescale 1ns/1ps

module demod_sequencer (
    input  logic                   clock,
    input  logic                   i_rst_n,
    input  logic                   i_in_empty,
    output logic                   o_in_rd_en,
    input  fm_stereo_pkg::sample_t i_in_sample,
    output logic                   o_front_shift,
    output logic                   o_front_start,
    output logic                   o_lpr_start,
    input  logic                   i_front_done,
    output logic                   o_hp_shift_start,
    input  logic                   i_hp_done,
    output logic                   o_square,
    output logic                   o_mix,
    output logic                   o_lmr_shift,
    output logic                   o_lmr_start,
    input  logic                   i_lmr_done,
    output logic                   o_form,
    input  logic                   i_out_full,
    output logic                   o_out_wr_en
);

    import fm_stereo_pkg::*;

    seq_state_t state;
    phase_t phase;
    phase_t next_phase;
    logic out_phase;
    logic can_start;

    assign out_phase = (phase == '0);
    // Room for the pair is checked before the sample is taken
    assign can_start = !i_in_empty && (!out_phase || !i_out_full);
    assign next_phase = (phase == phase_t'(AUDIO_DECIMATION - 1)) ? '0 : phase + 1'b1;

    // Strobes are registered and last one cycle after each transition
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state <= IDLE;
            phase <= '0;
            o_in_rd_en <= 1'b0;
            o_front_shift <= 1'b0;
            o_front_start <= 1'b0;
            o_lpr_start <= 1'b0;
            o_square <= 1'b0;
            o_hp_shift_start <= 1'b0;
            o_mix <= 1'b0;
            o_lmr_shift <= 1'b0;
            o_lmr_start <= 1'b0;
            o_form <= 1'b0;
            o_out_wr_en <= 1'b0;
        end else begin
            o_in_rd_en <= 1'b0;
            o_front_shift <= 1'b0;
            o_front_start <= 1'b0;
            o_lpr_start <= 1'b0;
            o_square <= 1'b0;
            o_hp_shift_start <= 1'b0;
            o_mix <= 1'b0;
            o_lmr_shift <= 1'b0;
            o_lmr_start <= 1'b0;
            o_form <= 1'b0;
            o_out_wr_en <= 1'b0;
            case (state)
                IDLE: begin
                    if (can_start) begin
                        o_in_rd_en <= 1'b1;
                        o_front_shift <= 1'b1;
                        o_front_start <= 1'b1;
                        o_lpr_start <= out_phase;
                        state <= FRONT;
                    end
                end
                // L+R low-pass finishes together with the band-pass pair
                FRONT: begin
                    if (i_front_done) begin
                        o_square <= 1'b1;
                        state <= SQUARE;
                    end
                end
                SQUARE: begin
                    o_hp_shift_start <= 1'b1;
                    state <= HP;
                end
                HP: begin
                    if (i_hp_done) begin
                        o_mix <= 1'b1;
                        state <= MIX;
                    end
                end
                MIX: begin
                    o_lmr_shift <= 1'b1;
                    o_lmr_start <= out_phase;
                    state <= LMR;
                end
                LMR: begin
                    if (!out_phase) begin
                        phase <= next_phase;
                        state <= IDLE;
                    end else if (i_lmr_done) begin
                        o_form <= 1'b1;
                        state <= FORM;
                    end
                end
                FORM: begin
                    o_out_wr_en <= 1'b1;
                    state <= WRITE;
                end
                WRITE: begin
                    phase <= next_phase;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_write_room: assert property (@(posedge clock) disable iff (!i_rst_n)
        o_out_wr_en |-> !i_out_full) else $error("output write while full");
    a_pop_valid: assert property (@(posedge clock) disable iff (!i_rst_n)
        o_in_rd_en |-> !i_in_empty && !$isunknown(i_in_sample))
        else $error("input popped without a valid sample");

endmodule

/* src/fm_stereo_top.sv */
`timescale 1ns/1ps

module fm_stereo_top #(
    parameter int IN_DEPTH = 16,
    parameter int OUT_DEPTH = 16
) (
    input  logic                   clock,
    input  logic                   i_rst_n,
    input  logic                   i_in_wr_en,
    input  fm_stereo_pkg::sample_t i_sample,
    output logic                   o_in_full,
    output fm_stereo_pkg::sample_t o_left_audio,
    output logic                   o_left_empty,
    input  logic                   i_left_rd_en,
    output fm_stereo_pkg::sample_t o_right_audio,
    output logic                   o_right_empty,
    input  logic                   i_right_rd_en
);

    import fm_stereo_pkg::*;

    // Input FIFO to sequencer and front filters
    logic in_rd_en;
    logic in_empty;
    sample_t in_sample;

    // Sequencer strobes
    logic front_shift;
    logic front_start;
    logic lpr_start;
    logic front_done;
    logic hp_shift_start;
    logic hp_done;
    logic square;
    logic mix;
    logic lmr_shift;
    logic lmr_start;
    logic lmr_done;
    logic form;
    logic out_wr_en;
    logic left_full;

    // Datapath
    sample_t pilot_band;
    sample_t lmr_band;
    sample_t lpr_audio;
    sample_t carrier_sq;
    sample_t carrier;
    sample_t mixed;
    sample_t lmr_audio;
    stereo_sample_t pair;

    sample_fifo #(.DEPTH(IN_DEPTH)) in_fifo_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_wr_en(i_in_wr_en), .i_data(i_sample), .o_full(o_in_full),
        .i_rd_en(in_rd_en), .o_data(in_sample), .o_empty(in_empty)
    );

    fir_mac #(.COEFFS(BP_PILOT_COEFFS)) bp_pilot_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_shift(front_shift), .i_sample(in_sample), .i_start(front_start),
        .o_done(front_done), .o_result(pilot_band)
    );

    fir_mac #(.COEFFS(BP_LMR_COEFFS)) bp_lmr_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_shift(front_shift), .i_sample(in_sample), .i_start(front_start),
        .o_done(), .o_result(lmr_band)
    );

    fir_mac #(.COEFFS(AUDIO_LPR_COEFFS)) lpr_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_shift(front_shift), .i_sample(in_sample), .i_start(lpr_start),
        .o_done(), .o_result(lpr_audio)
    );

    fir_mac #(.COEFFS(HP_COEFFS)) hp_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_shift(hp_shift_start), .i_sample(carrier_sq), .i_start(hp_shift_start),
        .o_done(hp_done), .o_result(carrier)
    );

    pilot_mixer mixer_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_square(square), .i_pilot(pilot_band), .o_carrier_sq(carrier_sq),
        .i_mix(mix), .i_carrier(carrier), .i_lmr_band(lmr_band), .o_mixed(mixed)
    );

    fir_mac #(.COEFFS(AUDIO_LMR_COEFFS)) lmr_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_shift(lmr_shift), .i_sample(mixed), .i_start(lmr_start),
        .o_done(lmr_done), .o_result(lmr_audio)
    );

    stereo_matrix matrix_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_form(form), .i_lpr(lpr_audio), .i_lmr(lmr_audio), .o_pair(pair)
    );

    sample_fifo #(.DEPTH(OUT_DEPTH)) left_fifo_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_wr_en(out_wr_en), .i_data(pair.left), .o_full(left_full),
        .i_rd_en(i_left_rd_en), .o_data(o_left_audio), .o_empty(o_left_empty)
    );

    // Right FIFO tracks the left count, so its full flag is left open
    sample_fifo #(.DEPTH(OUT_DEPTH)) right_fifo_inst (
        .clock(clock), .i_rst_n(i_rst_n),
        .i_wr_en(out_wr_en), .i_data(pair.right), .o_full(),
        .i_rd_en(i_right_rd_en), .o_data(o_right_audio), .o_empty(o_right_empty)
    );

    demod_sequencer sequencer_inst (
        .clock(clock),
        .i_rst_n(i_rst_n),
        .i_in_empty(in_empty),
        .o_in_rd_en(in_rd_en),
        .i_in_sample(in_sample),
        .o_front_shift(front_shift),
        .o_front_start(front_start),
        .o_lpr_start(lpr_start),
        .i_front_done(front_done),
        .o_hp_shift_start(hp_shift_start),
        .i_hp_done(hp_done),
        .o_square(square),
        .o_mix(mix),
        .o_lmr_shift(lmr_shift),
        .o_lmr_start(lmr_start),
        .i_lmr_done(lmr_done),
        .o_form(form),
        .i_out_full(left_full),
        .o_out_wr_en(out_wr_en)
    );

endmodule

/* verification/fm_stereo_tb.sv */
`timescale 1ns/1ps

module fm_stereo_tb;

    import fm_stereo_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int IN_DEPTH = 16;
    localparam int OUT_DEPTH = 4;
    localparam int CYCLES_PER_SAMPLE = 200;
    localparam int STALL_WRITES = IN_DEPTH + OUT_DEPTH * AUDIO_DECIMATION;
    localparam int STALL_HOLD_CYCLES = 4 * (NUM_TAPS + 2);
    localparam int DRAIN_CYCLES = AUDIO_DECIMATION * 4 * (NUM_TAPS + 2);
    localparam logic [31:0] RAND_SEED = 32'h5a20_c866;
    localparam string STIM_FILE = "verification/fm_stereo_stimulus.txt";

    logic clock;
    logic i_rst_n;
    logic i_in_wr_en;
    sample_t i_sample;
    logic o_in_full;
    sample_t o_left_audio;
    logic o_left_empty;
    logic i_left_rd_en;
    sample_t o_right_audio;
    logic o_right_empty;
    logic i_right_rd_en;

    sample_t in_q[$];
    stereo_sample_t exp_q[$];
    bit stimulus_loaded;
    int writes_done;

    fm_stereo_top #(
        .IN_DEPTH(IN_DEPTH),
        .OUT_DEPTH(OUT_DEPTH)
    ) dut (
        .clock(clock),
        .i_rst_n(i_rst_n),
        .i_in_wr_en(i_in_wr_en),
        .i_sample(i_sample),
        .o_in_full(o_in_full),
        .o_left_audio(o_left_audio),
        .o_left_empty(o_left_empty),
        .i_left_rd_en(i_left_rd_en),
        .o_right_audio(o_right_audio),
        .o_right_empty(o_right_empty),
        .i_right_rd_en(i_right_rd_en)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_pair(input stereo_sample_t expected, input stereo_sample_t actual,
                              input int index);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at %0t ns: pair %0d is (%0d, %0d), expected (%0d, %0d)",
                $time, index, actual.left, actual.right, expected.left, expected.right));
        end
    endtask

    task automatic check_flag(input bit expected, input bit actual, input string name);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %0b, expected %0b",
                $time, name, actual, expected));
        end
    endtask

    task automatic load_stimulus();
        int fd;
        int code;
        int value;
        int left;
        int right;
        logic [7:0] tag;
        string rest;
        bit done;
        stereo_sample_t exp_pair;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("The stimulus file could not be opened");
        end
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", tag);
            if (code != 1) begin
                done = 1'b1;
            end else if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "I") begin
                for (int k = 0; k < AUDIO_DECIMATION; k++) begin
                    code = $fscanf(fd, "%d", value);
                    if (code != 1) begin
                        abort_run("An input line of the stimulus file is too short");
                    end
                    in_q.push_back(sample_t'(value));
                end
            end else if (tag == "E") begin
                code = $fscanf(fd, "%d %d", left, right);
                if (code != 2) begin
                    abort_run("An expected line of the stimulus file is too short");
                end
                exp_pair.left = sample_t'(left);
                exp_pair.right = sample_t'(right);
                exp_q.push_back(exp_pair);
            end else begin
                abort_run("The stimulus file holds a line of unknown kind");
            end
        end
        $fclose(fd);
        if (in_q.size() != exp_q.size() * AUDIO_DECIMATION) begin
            abort_run("The stimulus file does not hold one expected pair per block");
        end
    endtask

    task automatic reset_dut();
        repeat (2) @(posedge clock);
        i_rst_n <= 1'b1;
        @(negedge clock);
        check_flag(1'b1, o_left_empty, "o_left_empty after reset");
        check_flag(1'b1, o_right_empty, "o_right_empty after reset");
        check_flag(1'b0, o_in_full, "o_in_full after reset");
    endtask

    // Full is sampled with the write strobe low, so a write never lands on a full FIFO
    task automatic drive_samples();
        foreach (in_q[n]) begin
            @(negedge clock);
            while (o_in_full) @(negedge clock);
            @(posedge clock);
            i_in_wr_en <= 1'b1;
            i_sample <= in_q[n];
            @(posedge clock);
            i_in_wr_en <= 1'b0;
            writes_done++;
        end
    endtask

    task automatic pop_pair(output stereo_sample_t pair);
        while (o_left_empty) @(negedge clock);
        pair.left = o_left_audio;
        pair.right = o_right_audio;
        @(posedge clock);
        i_left_rd_en <= 1'b1;
        i_right_rd_en <= 1'b1;
        @(posedge clock);
        i_left_rd_en <= 1'b0;
        i_right_rd_en <= 1'b0;
        @(negedge clock);
    endtask

    task automatic read_pairs();
        stereo_sample_t got;
        // Four pairs fill the 4-deep outputs, so the next phase 0 sample waits at the input
        while (!(o_in_full && writes_done >= STALL_WRITES)) @(negedge clock);
        // Longer than one sample pass, so a running sequencer would pop another sample
        repeat (STALL_HOLD_CYCLES) @(negedge clock);
        check_flag(1'b1, o_in_full, "o_in_full during the stall");
        check_flag(1'b1, writes_done == STALL_WRITES, "writes stopped at the stall point");
        check_flag(1'b0, o_left_empty, "o_left_empty during the stall");
        foreach (exp_q[n]) begin
            repeat ($urandom % 4) @(negedge clock);
            pop_pair(got);
            check_pair(exp_q[n], got, n);
        end
    endtask

    task automatic check_drain();
        repeat (DRAIN_CYCLES) begin
            @(negedge clock);
            check_flag(1'b1, o_left_empty, "o_left_empty after the last pair");
            check_flag(1'b1, o_right_empty, "o_right_empty after the last pair");
        end
        check_flag(1'b0, o_in_full, "o_in_full after the run");
    endtask

    always @(negedge clock) begin
        if (i_rst_n) begin
            check_flag(o_left_empty, o_right_empty, "o_right_empty against o_left_empty");
        end
    end

    initial begin : watchdog
        int timeout_ns;
        wait (stimulus_loaded);
        timeout_ns = in_q.size() * CYCLES_PER_SAMPLE * CLK_PERIOD;
        #(timeout_ns);
        abort_run($sformatf("Timeout: the run did not finish within %0d ns", timeout_ns));
    end

    initial begin
        clock = 1'b0;
        i_rst_n = 1'b0;
        i_in_wr_en = 1'b0;
        i_sample = '0;
        i_left_rd_en = 1'b0;
        i_right_rd_en = 1'b0;
        writes_done = 0;
        stimulus_loaded = 1'b0;
        void'($urandom(RAND_SEED));
        load_stimulus();
        stimulus_loaded = 1'b1;
        reset_dut();
        fork
            drive_samples();
            read_pairs();
        join
        check_drain();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verification/fm_stereo_stimulus.txt */
# I: one decimation block of eight composite input samples, signed decimal, oldest first
# E: expected left and right audio words for the block just above, signed decimal
I 0 0 0 0 0 0 0 0
E 0 0
I 0 0 0 0 0 0 0 0
E 0 0
I 100 0 0 0 0 0 0 0
E -1 -1
I 0 0 0 0 0 0 0 0
E 2 2
I 0 0 0 0 0 0 0 0
E 56 56
I 0 0 0 0 0 0 0 0
E -4 0
I 0 0 0 0 0 0 0 0
E -2 2
I 0 0 0 0 0 0 0 0
E -1 1

/* all.f */
src/fm_stereo_pkg.sv
src/sample_fifo.sv
src/fir_mac.sv
src/pilot_mixer.sv
src/stereo_matrix.sv
src/demod_sequencer.sv
src/fm_stereo_top.sv
verification/fm_stereo_tb.sv
